//--- Bender.yml
package:
  name: eth_frame_detector

sources:
  - include_dirs:
      - include
    files:
      - src/eth_frame_detector_pkg.sv
      - src/eth_frame_detector_dram.sv
      - src/eth_frame_detector_mem_arbiter.sv
      - src/eth_frame_detector_axi_dram.sv
      - src/eth_frame_detector_matcher.sv
      - src/eth_frame_detector_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/eth_frame_detector_tb.sv

//--- eth_frame_detector.f
+incdir+include
src/eth_frame_detector_pkg.sv
src/eth_frame_detector_dram.sv
src/eth_frame_detector_mem_arbiter.sv
src/eth_frame_detector_axi_dram.sv
src/eth_frame_detector_matcher.sv
src/eth_frame_detector_top.sv
test/eth_frame_detector_tb.sv

//--- include/eth_frame_detector_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths and memory layout for the frame detector.
// pattern and mask words must not overlap in memory.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ETH_FRAME_DETECTOR_MACROS_SVH
`define ETH_FRAME_DETECTOR_MACROS_SVH

// memory word and address widths.
`define EFD_DATA_W 32
`define EFD_HOST_ADDR_W 16
`define EFD_MEM_ADDR_W 11

// pattern layout, in word addresses.
`define EFD_PATTERN_WORDS 4
`define EFD_PATTERN_BASE 0
`define EFD_MASK_BASE 4

// receive byte fifo depth, equal to the sender's credits.
`define EFD_RX_CREDITS 4

`endif

//--- src/eth_frame_detector_axi_dram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host bridge, every write is a read-modify-write.
// byte address bits 1:0 are ignored.
// host must wait for done before the next request.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "eth_frame_detector_macros.svh"

module eth_frame_detector_axi_dram (
	input logic clk,
	input logic rst_n,

	input logic read_req,
	input logic write_req,
	input eth_frame_detector_pkg::host_addr_t read_addr,
	input eth_frame_detector_pkg::host_addr_t write_addr,
	input eth_frame_detector_pkg::mem_word_t write_mask,
	input eth_frame_detector_pkg::mem_word_t write_data,

	output logic done,
	output eth_frame_detector_pkg::mem_word_t read_data,

	output logic mem_req,
	output logic mem_we,
	input logic mem_ack,
	output eth_frame_detector_pkg::mem_addr_t mem_addr,
	output eth_frame_detector_pkg::mem_word_t mem_wdata,
	input eth_frame_detector_pkg::mem_word_t mem_rdata
);
	eth_frame_detector_pkg::bridge_state_t state;

	logic mem_ack_q;
	logic write_pending;
	logic mem_done;
	eth_frame_detector_pkg::mem_word_t mask_q;

	// access ends on the first cycle after ack.
	assign mem_done = mem_ack_q & ~mem_ack;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= eth_frame_detector_pkg::BR_IDLE;
			mem_req <= 1'b0;
			mem_we <= 1'b0;
			mem_addr <= '0;
			mem_wdata <= '0;
			mask_q <= '0;
			write_pending <= 1'b0;
			mem_ack_q <= 1'b0;
			done <= 1'b0;
			read_data <= '0;
		end else begin
			mem_ack_q <= mem_ack;
			done <= 1'b0;

			case (state)
				eth_frame_detector_pkg::BR_IDLE: begin
					// write wins when both arrive together.
					if (write_req) begin
						state <= eth_frame_detector_pkg::BR_READ_MEM;
						mem_req <= 1'b1;
						mem_we <= 1'b0;
						mem_addr <= write_addr[`EFD_MEM_ADDR_W+1:2];
						mem_wdata <= write_data;
						mask_q <= write_mask;
						write_pending <= 1'b1;
					end else if (read_req) begin
						state <= eth_frame_detector_pkg::BR_READ_MEM;
						mem_req <= 1'b1;
						mem_we <= 1'b0;
						mem_addr <= read_addr[`EFD_MEM_ADDR_W+1:2];
						write_pending <= 1'b0;
					end
				end

				eth_frame_detector_pkg::BR_READ_MEM: begin
					if (mem_ack) begin
						mem_req <= 1'b0;
					end else if (mem_done) begin
						if (write_pending) begin
							// merge new bits over the old word.
							state <= eth_frame_detector_pkg::BR_WRITE_MEM;
							mem_req <= 1'b1;
							mem_we <= 1'b1;
							mem_wdata <= (mem_wdata & mask_q) | (mem_rdata & ~mask_q);
							write_pending <= 1'b0;
						end else begin
							state <= eth_frame_detector_pkg::BR_IDLE;
							read_data <= mem_rdata;
							done <= 1'b1;
						end
					end
				end

				eth_frame_detector_pkg::BR_WRITE_MEM: begin
					if (mem_ack) begin
						mem_req <= 1'b0;
					end else if (mem_done) begin
						state <= eth_frame_detector_pkg::BR_IDLE;
						mem_we <= 1'b0;
						done <= 1'b1;
					end
				end

				default: begin
					state <= eth_frame_detector_pkg::BR_IDLE;
				end
			endcase
		end
	end

endmodule

//--- src/eth_frame_detector_dram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-port word memory, req/ack pulse protocol.
// contents are not cleared by reset.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "eth_frame_detector_macros.svh"

module eth_frame_detector_dram (
	input logic clk,
	input logic rst_n,
	input logic req,
	input logic we,
	input eth_frame_detector_pkg::mem_addr_t addr,
	input eth_frame_detector_pkg::mem_word_t wdata,
	output logic ack,
	output eth_frame_detector_pkg::mem_word_t rdata
);
	localparam int DEPTH = 2 ** `EFD_MEM_ADDR_W;

	eth_frame_detector_pkg::mem_word_t mem [DEPTH];

	logic accept;

	// req is still high during the ack cycle, so skip it.
	assign accept = req & ~ack;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack <= 1'b0;
		end else begin
			ack <= accept;
		end
	end

	// read returns the old word on a write.
	always_ff @(posedge clk) begin
		if (accept) begin
			rdata <= mem[addr];
			if (we) begin
				mem[addr] <= wdata;
			end
		end
	end

endmodule

//--- src/eth_frame_detector_matcher.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-frame masked compare of the first pattern bytes.
// pattern and mask are reloaded for every frame.
// sender must respect the credit count.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "eth_frame_detector_macros.svh"

module eth_frame_detector_matcher (
	input logic clk,
	input logic rst_n,
	input logic rx_valid,
	input logic rx_last,
	input eth_frame_detector_pkg::rx_byte_t rx_data,
	output logic rx_credit,
	output logic mem_req,
	output eth_frame_detector_pkg::mem_addr_t mem_addr,
	input logic mem_ack,
	input eth_frame_detector_pkg::mem_word_t mem_rdata,
	output logic match_valid,
	output logic match_hit
);
	localparam int DEPTH = `EFD_RX_CREDITS;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int WORDS = `EFD_PATTERN_WORDS;
	localparam int PAT_BYTES = WORDS * 4;
	localparam int POS_W = $clog2(PAT_BYTES + 1);
	localparam int LOAD_W = $clog2(2 * WORDS);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// receive fifo
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	eth_frame_detector_pkg::rx_byte_t fifo_data [DEPTH];
	logic fifo_last [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic pop;

	eth_frame_detector_pkg::match_state_t state;

	assign pop = (state == eth_frame_detector_pkg::MS_COMPARE) && (count != '0);

	always_ff @(posedge clk) begin
		if (rx_valid) begin
			fifo_data[wr_ptr] <= rx_data;
			fifo_last[wr_ptr] <= rx_last;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			rx_credit <= 1'b0;
		end else begin
			if (rx_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({rx_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit back per popped byte.
			rx_credit <= pop;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pattern load and compare
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	eth_frame_detector_pkg::mem_word_t pattern_q [WORDS];
	eth_frame_detector_pkg::mem_word_t mask_q [WORDS];
	logic [LOAD_W-1:0] load_idx;
	logic [POS_W-1:0] byte_pos;
	logic mem_ack_q;
	logic hit_q;
	logic short_miss;
	eth_frame_detector_pkg::rx_byte_t pat_byte;
	eth_frame_detector_pkg::rx_byte_t msk_byte;

	// pattern words first, then mask words.
	function automatic eth_frame_detector_pkg::mem_addr_t load_addr(input logic [LOAD_W-1:0] idx);
		if (idx < WORDS) begin
			return eth_frame_detector_pkg::mem_addr_t'(`EFD_PATTERN_BASE + idx);
		end
		return eth_frame_detector_pkg::mem_addr_t'(`EFD_MASK_BASE + idx - WORDS);
	endfunction

	assign pat_byte = pattern_q[byte_pos[POS_W-2:2]][{byte_pos[1:0], 3'b000} +: 8];
	assign msk_byte = mask_q[byte_pos[POS_W-2:2]][{byte_pos[1:0], 3'b000} +: 8];

	// a short frame misses if a missing byte is masked in.
	always_comb begin
		short_miss = 1'b0;
		for (int i = 0; i < PAT_BYTES; i++) begin
			if (i >= byte_pos && mask_q[i / 4][8 * (i % 4) +: 8] != '0) begin
				short_miss = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == eth_frame_detector_pkg::MS_LOAD && mem_ack) begin
			if (load_idx < WORDS) begin
				pattern_q[load_idx[LOAD_W-2:0]] <= mem_rdata;
			end else begin
				mask_q[load_idx[LOAD_W-2:0]] <= mem_rdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= eth_frame_detector_pkg::MS_IDLE;
			mem_req <= 1'b0;
			mem_addr <= '0;
			mem_ack_q <= 1'b0;
			load_idx <= '0;
			byte_pos <= '0;
			hit_q <= 1'b0;
			match_valid <= 1'b0;
			match_hit <= 1'b0;
		end else begin
			mem_ack_q <= mem_ack;
			match_valid <= 1'b0;

			case (state)
				eth_frame_detector_pkg::MS_IDLE: begin
					if (count != '0) begin
						state <= eth_frame_detector_pkg::MS_LOAD;
						load_idx <= '0;
						mem_req <= 1'b1;
						mem_addr <= load_addr('0);
					end
				end

				eth_frame_detector_pkg::MS_LOAD: begin
					if (mem_ack) begin
						mem_req <= 1'b0;
					end else if (mem_ack_q) begin
						if (load_idx == LOAD_W'(2 * WORDS - 1)) begin
							state <= eth_frame_detector_pkg::MS_COMPARE;
							byte_pos <= '0;
							hit_q <= 1'b1;
						end else begin
							load_idx <= load_idx + 1'b1;
							mem_req <= 1'b1;
							mem_addr <= load_addr(load_idx + 1'b1);
						end
					end
				end

				eth_frame_detector_pkg::MS_COMPARE: begin
					if (pop) begin
						// bytes past the pattern are only drained.
						if (byte_pos < POS_W'(PAT_BYTES)) begin
							if (((fifo_data[rd_ptr] ^ pat_byte) & msk_byte) != '0) begin
								hit_q <= 1'b0;
							end
							byte_pos <= byte_pos + 1'b1;
						end
						if (fifo_last[rd_ptr]) begin
							state <= eth_frame_detector_pkg::MS_REPORT;
						end
					end
				end

				eth_frame_detector_pkg::MS_REPORT: begin
					state <= eth_frame_detector_pkg::MS_IDLE;
					match_valid <= 1'b1;
					match_hit <= hit_q & ~short_miss;
				end

				default: begin
					state <= eth_frame_detector_pkg::MS_IDLE;
				end
			endcase
		end
	end

endmodule

//--- src/eth_frame_detector_mem_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-way arbiter for the word memory.
// matcher has priority, grants are never preempted.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module eth_frame_detector_mem_arbiter (
	input logic clk,
	input logic rst_n,

	input logic host_req,
	input logic host_we,
	input eth_frame_detector_pkg::mem_addr_t host_addr,
	input eth_frame_detector_pkg::mem_word_t host_wdata,
	output logic host_ack,
	output eth_frame_detector_pkg::mem_word_t host_rdata,

	input logic mat_req,
	input eth_frame_detector_pkg::mem_addr_t mat_addr,
	output logic mat_ack,
	output eth_frame_detector_pkg::mem_word_t mat_rdata,

	output logic mem_req,
	output logic mem_we,
	output eth_frame_detector_pkg::mem_addr_t mem_addr,
	output eth_frame_detector_pkg::mem_word_t mem_wdata,
	input logic mem_ack,
	input eth_frame_detector_pkg::mem_word_t mem_rdata
);
	logic grant_valid;
	logic grant_mat;
	logic mem_ack_q;
	logic sel_mat;

	// without a grant, a new request is routed straight through.
	assign sel_mat = grant_valid ? grant_mat : mat_req;

	assign mem_req = sel_mat ? mat_req : host_req;
	assign mem_we = sel_mat ? 1'b0 : host_we;
	assign mem_addr = sel_mat ? mat_addr : host_addr;
	assign mem_wdata = host_wdata;

	assign host_ack = mem_ack & ~sel_mat;
	assign mat_ack = mem_ack & sel_mat;
	assign host_rdata = mem_rdata;
	assign mat_rdata = mem_rdata;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grant_valid <= 1'b0;
			grant_mat <= 1'b0;
			mem_ack_q <= 1'b0;
		end else begin
			mem_ack_q <= mem_ack;
			if (grant_valid) begin
				// release on the completion cycle.
				if (mem_ack_q && !mem_ack) begin
					grant_valid <= 1'b0;
				end
			end else if (mat_req || host_req) begin
				grant_valid <= 1'b1;
				grant_mat <= mat_req;
			end
		end
	end

endmodule

//--- src/eth_frame_detector_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the frame detector.
// widths come from the macros header.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "eth_frame_detector_macros.svh"

package eth_frame_detector_pkg;

	// data path vectors.
	typedef logic [`EFD_DATA_W-1:0] mem_word_t;
	typedef logic [`EFD_MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [`EFD_HOST_ADDR_W-1:0] host_addr_t;
	typedef logic [7:0] rx_byte_t;

	// host bridge fsm.
	typedef enum logic [1:0] {
		BR_IDLE,
		BR_READ_MEM,
		BR_WRITE_MEM
	} bridge_state_t;

	// frame matcher fsm.
	typedef enum logic [1:0] {
		MS_IDLE,
		MS_LOAD,
		MS_COMPARE,
		MS_REPORT
	} match_state_t;

endpackage

//--- src/eth_frame_detector_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame detector top, wiring only.
// host and matcher share one memory port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module eth_frame_detector_top (
	input logic clk,
	input logic rst_n,

	input logic read_req,
	input eth_frame_detector_pkg::host_addr_t read_addr,
	input logic write_req,
	input eth_frame_detector_pkg::mem_word_t write_mask,
	input eth_frame_detector_pkg::host_addr_t write_addr,
	input eth_frame_detector_pkg::mem_word_t write_data,
	output logic done,
	output eth_frame_detector_pkg::mem_word_t read_data,

	input logic rx_valid,
	input eth_frame_detector_pkg::rx_byte_t rx_data,
	input logic rx_last,
	output logic rx_credit,

	output logic match_valid,
	output logic match_hit
);
	// bridge to arbiter.
	logic host_req;
	logic host_we;
	logic host_ack;
	eth_frame_detector_pkg::mem_addr_t host_addr;
	eth_frame_detector_pkg::mem_word_t host_wdata;
	eth_frame_detector_pkg::mem_word_t host_rdata;

	// matcher to arbiter.
	logic mat_req;
	logic mat_ack;
	eth_frame_detector_pkg::mem_addr_t mat_addr;
	eth_frame_detector_pkg::mem_word_t mat_rdata;

	// arbiter to memory.
	logic mem_req;
	logic mem_we;
	logic mem_ack;
	eth_frame_detector_pkg::mem_addr_t mem_addr;
	eth_frame_detector_pkg::mem_word_t mem_wdata;
	eth_frame_detector_pkg::mem_word_t mem_rdata;

	eth_frame_detector_axi_dram axi_dram_inst (
		.clk(clk), .rst_n(rst_n),
		.read_req(read_req), .write_req(write_req),
		.read_addr(read_addr), .write_addr(write_addr),
		.write_mask(write_mask), .write_data(write_data),
		.done(done), .read_data(read_data),
		.mem_req(host_req), .mem_we(host_we), .mem_ack(host_ack),
		.mem_addr(host_addr), .mem_wdata(host_wdata), .mem_rdata(host_rdata)
	);

	eth_frame_detector_matcher matcher_inst (
		.clk(clk), .rst_n(rst_n),
		.rx_valid(rx_valid), .rx_last(rx_last), .rx_data(rx_data), .rx_credit(rx_credit),
		.mem_req(mat_req), .mem_addr(mat_addr), .mem_ack(mat_ack), .mem_rdata(mat_rdata),
		.match_valid(match_valid), .match_hit(match_hit)
	);

	eth_frame_detector_mem_arbiter mem_arbiter_inst (
		.clk(clk), .rst_n(rst_n),
		.host_req(host_req), .host_we(host_we), .host_addr(host_addr),
		.host_wdata(host_wdata), .host_ack(host_ack), .host_rdata(host_rdata),
		.mat_req(mat_req), .mat_addr(mat_addr), .mat_ack(mat_ack), .mat_rdata(mat_rdata),
		.mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

	eth_frame_detector_dram dram_inst (
		.clk(clk), .rst_n(rst_n),
		.req(mem_req), .we(mem_we), .addr(mem_addr), .wdata(mem_wdata),
		.ack(mem_ack), .rdata(mem_rdata)
	);

endmodule

//--- test/eth_frame_detector_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// table-driven testbench for the frame detector.
// the table writes pattern and mask before any frame.
// memory words are read only after they are written.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "eth_frame_detector_macros.svh"

module eth_frame_detector_tb;
	localparam int NUM_ENTRIES = 27;
	localparam int CYCLE_LIMIT = 300 * NUM_ENTRIES + 10;
	localparam int KIND_WRITE = 0;
	localparam int KIND_READ = 1;
	localparam int KIND_FRAME = 2;
	localparam int MODEL_WORDS = 2 ** `EFD_MEM_ADDR_W;

	logic clk = 1'b0;
	logic rst_n;
	logic read_req;
	logic write_req;
	eth_frame_detector_pkg::host_addr_t read_addr;
	eth_frame_detector_pkg::host_addr_t write_addr;
	eth_frame_detector_pkg::mem_word_t write_mask;
	eth_frame_detector_pkg::mem_word_t write_data;
	logic done;
	eth_frame_detector_pkg::mem_word_t read_data;
	logic rx_valid = 1'b0;
	logic rx_last = 1'b0;
	eth_frame_detector_pkg::rx_byte_t rx_data = '0;
	logic rx_credit;
	logic match_valid;
	logic match_hit;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus table and model state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	string t_name [NUM_ENTRIES];
	int t_kind [NUM_ENTRIES];
	bit t_bg [NUM_ENTRIES];
	eth_frame_detector_pkg::host_addr_t t_addr [NUM_ENTRIES];
	eth_frame_detector_pkg::mem_word_t t_data [NUM_ENTRIES];
	eth_frame_detector_pkg::mem_word_t t_mask [NUM_ENTRIES];
	logic [159:0] t_bytes [NUM_ENTRIES];
	int t_len [NUM_ENTRIES];
	bit t_hit [NUM_ENTRIES];
	int n_entries = 0;

	eth_frame_detector_pkg::mem_word_t model_mem [MODEL_WORDS];
	eth_frame_detector_pkg::rx_byte_t tx_data_q [$];
	bit tx_last_q [$];
	string exp_name_q [$];
	bit exp_hit_q [$];

	integer seed = 13;
	int credits = `EFD_RX_CREDITS;
	int gap = 0;
	int cycles = 0;
	int value_errors = 0;
	int other_errors = 0;

	always #20 clk = ~clk;

	eth_frame_detector_top eth_frame_detector_top_inst (
		.clk(clk), .rst_n(rst_n),
		.read_req(read_req), .read_addr(read_addr),
		.write_req(write_req), .write_mask(write_mask),
		.write_addr(write_addr), .write_data(write_data),
		.done(done), .read_data(read_data),
		.rx_valid(rx_valid), .rx_data(rx_data), .rx_last(rx_last), .rx_credit(rx_credit),
		.match_valid(match_valid), .match_hit(match_hit)
	);

	function automatic void add_write(input string name, input logic [15:0] addr,
			input logic [31:0] data, input logic [31:0] mask);
		t_name[n_entries] = name;
		t_kind[n_entries] = KIND_WRITE;
		t_bg[n_entries] = 1'b0;
		t_addr[n_entries] = addr;
		t_data[n_entries] = data;
		t_mask[n_entries] = mask;
		t_bytes[n_entries] = '0;
		t_len[n_entries] = 0;
		t_hit[n_entries] = 1'b0;
		n_entries++;
	endfunction

	function automatic void add_read(input string name, input logic [15:0] addr);
		add_write(name, addr, '0, '0);
		t_kind[n_entries - 1] = KIND_READ;
	endfunction

	// frame bytes copy the pattern and add a tail, and flip is xored over the first 16.
	function automatic void add_frame(input string name, input bit bg, input int len,
			input logic [127:0] flip, input bit hit);
		logic [159:0] fb;
		for (int i = 0; i < 20; i++) begin
			fb[8*i +: 8] = (i < 16) ? 8'(17 * i) : 8'(8'hc0 + i);
		end
		add_write(name, '0, '0, '0);
		t_kind[n_entries - 1] = KIND_FRAME;
		t_bg[n_entries - 1] = bg;
		t_bytes[n_entries - 1] = fb ^ {32'h0, flip};
		t_len[n_entries - 1] = len;
		t_hit[n_entries - 1] = hit;
	endfunction

	function automatic void build_table();
		add_write("pat_w0", 16'h0000, 32'h33221100, 32'hffffffff);
		add_write("pat_w1", 16'h0004, 32'h77665544, 32'hffffffff);
		add_write("pat_w2", 16'h0008, 32'hbbaa9988, 32'hffffffff);
		add_write("pat_w3", 16'h000c, 32'hffeeddcc, 32'hffffffff);
		add_write("mask_w0", 16'h0010, 32'hffffffff, 32'hffffffff);
		add_write("mask_w1", 16'h0014, 32'h0f0fffff, 32'hffffffff);
		add_write("mask_w2", 16'h0018, 32'h00ff00ff, 32'hffffffff);
		add_write("mask_w3", 16'h001c, 32'h000000ff, 32'hffffffff);
		add_write("full_write", 16'h0190, 32'hcafef00d, 32'hffffffff);
		add_read("full_read_alias", 16'h0193);
		add_write("partial_write", 16'h0191, 32'h12345678, 32'h00ffff00);
		add_read("partial_read", 16'h0190);
		add_read("pattern_read", 16'h0006);
		add_frame("frame_exact", 1'b0, 16, '0, 1'b1);
		add_frame("frame_unmasked_diff", 1'b0, 20, (128'hf0 << 48) | (128'hff << 72), 1'b1);
		add_frame("frame_masked_bit", 1'b0, 16, 128'h01 << 80, 1'b0);
		add_frame("frame_short_miss", 1'b0, 10, '0, 1'b0);
		add_frame("frame_short_hit", 1'b0, 13, '0, 1'b1);
		// burst results do not depend on the mask update below.
		add_frame("burst_exact", 1'b1, 16, '0, 1'b1);
		add_frame("burst_byte0", 1'b1, 16, 128'h80, 1'b0);
		add_frame("burst_long", 1'b1, 20, '0, 1'b1);
		add_frame("burst_unmasked", 1'b1, 16, 128'hff << 112, 1'b1);
		add_write("mask_update", 16'h001c, 32'h0000ff00, 32'h0000ff00);
		add_read("mask_readback", 16'h001c);
		add_frame("after_short", 1'b0, 13, '0, 1'b0);
		add_frame("after_byte13", 1'b0, 16, 128'h01 << 104, 1'b0);
		add_frame("after_exact", 1'b0, 16, '0, 1'b1);
	endfunction

	function automatic void clear_model();
		for (int a = 0; a < MODEL_WORDS; a++) begin
			model_mem[a] = '0;
		end
	endfunction

	function automatic logic [31:0] model_word(input int a);
		return model_mem[a];
	endfunction

	// masked compare of the first 16 bytes where each missing byte needs a zero mask.
	function automatic bit model_hit(input int idx);
		logic [31:0] pw;
		logic [31:0] mw;
		logic [7:0] p;
		logic [7:0] m;
		logic [7:0] b;
		bit hit;
		hit = 1'b1;
		for (int i = 0; i < 4 * `EFD_PATTERN_WORDS; i++) begin
			pw = model_word(`EFD_PATTERN_BASE + i / 4);
			mw = model_word(`EFD_MASK_BASE + i / 4);
			p = pw[8*(i%4) +: 8];
			m = mw[8*(i%4) +: 8];
			b = t_bytes[idx][8*i +: 8];
			if (i >= t_len[idx]) begin
				if (m != 8'h00) begin
					hit = 1'b0;
				end
			end else if (((b ^ p) & m) != 8'h00) begin
				hit = 1'b0;
			end
		end
		return hit;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// host port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic host_write(input int idx);
		int w;
		w = int'(t_addr[idx][`EFD_MEM_ADDR_W+1:2]);
		@(negedge clk);
		write_addr = t_addr[idx];
		write_data = t_data[idx];
		write_mask = t_mask[idx];
		write_req = 1'b1;
		@(negedge clk);
		write_req = 1'b0;
		while (done !== 1'b1) @(negedge clk);
		// new bits where the mask is set, old bits elsewhere.
		model_mem[w] = (t_data[idx] & t_mask[idx]) | (model_word(w) & ~t_mask[idx]);
	endtask

	task automatic host_read(input int idx);
		logic [31:0] exp;
		exp = model_word(int'(t_addr[idx][`EFD_MEM_ADDR_W+1:2]));
		@(negedge clk);
		read_addr = t_addr[idx];
		read_req = 1'b1;
		@(negedge clk);
		read_req = 1'b0;
		while (done !== 1'b1) @(negedge clk);
		if (read_data !== exp) begin
			value_errors++;
			$display("ERR %s: expected %h, got %h", t_name[idx], exp, read_data);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// frame source and report monitor
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic queue_frame(input int idx);
		bit exp;
		exp = model_hit(idx);
		if (exp != t_hit[idx]) begin
			other_errors++;
			$display("table entry %s does not agree with the pattern model", t_name[idx]);
		end
		@(posedge clk);
		for (int i = 0; i < t_len[idx]; i++) begin
			tx_data_q.push_back(t_bytes[idx][8*i +: 8]);
			tx_last_q.push_back(i == t_len[idx] - 1);
		end
		exp_name_q.push_back(t_name[idx]);
		exp_hit_q.push_back(exp);
		if (!t_bg[idx]) begin
			while (exp_hit_q.size() != 0) @(posedge clk);
		end
	endtask

	always @(negedge clk) begin
		if (!rst_n) begin
			rx_valid = 1'b0;
			rx_last = 1'b0;
			credits = `EFD_RX_CREDITS;
			gap = 0;
		end else begin
			if (rx_credit === 1'b1) begin
				credits++;
			end
			if (credits > `EFD_RX_CREDITS) begin
				other_errors++;
				$display("credit count %0d exceeds the limit of %0d", credits, `EFD_RX_CREDITS);
			end
			rx_valid = 1'b0;
			rx_last = 1'b0;
			if (gap != 0) begin
				gap--;
			end else if (tx_data_q.size() != 0 && credits > 0) begin
				rx_data = tx_data_q.pop_front();
				rx_last = tx_last_q.pop_front();
				rx_valid = 1'b1;
				credits--;
				gap = $unsigned($random(seed)) % 3;
			end
		end
	end

	always @(negedge clk) begin : report_check
		string name;
		bit exp;
		if (rst_n === 1'b1 && match_valid === 1'b1) begin
			if (exp_hit_q.size() == 0) begin
				other_errors++;
				$display("frame report seen with no frame outstanding");
			end else begin
				name = exp_name_q.pop_front();
				exp = exp_hit_q.pop_front();
				if (match_hit !== exp) begin
					value_errors++;
					$display("ERR %s: expected %0b, got %0b", name, exp, match_hit);
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// run control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic finish_run();
		$display("errors: value=%0d other=%0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	endtask

	initial begin : watchdog
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		other_errors++;
		$display("timeout, run stopped after %0d cycles", CYCLE_LIMIT);
		finish_run();
	end

	initial begin : main_flow
		rst_n = 1'b0;
		read_req = 1'b0;
		write_req = 1'b0;
		read_addr = '0;
		write_addr = '0;
		write_mask = '0;
		write_data = '0;
		clear_model();
		build_table();
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);
		for (int e = 0; e < n_entries; e++) begin
			case (t_kind[e])
				KIND_WRITE: host_write(e);
				KIND_READ: host_read(e);
				default: queue_frame(e);
			endcase
		end
		while (exp_hit_q.size() != 0 || tx_data_q.size() != 0) @(posedge clk);
		// last credits arrive a few cycles after the final pop.
		for (int k = 0; k < 20 && credits != `EFD_RX_CREDITS; k++) begin
			@(posedge clk);
		end
		if (credits != `EFD_RX_CREDITS) begin
			other_errors++;
			$display("credits missing at the end, %0d of %0d returned", credits,
				`EFD_RX_CREDITS);
		end
		finish_run();
	end

endmodule
